// File: Makefile
TOP := tb_rvv_alu_other

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: design/alu_extend.sv
`timescale 1ns/1ps
`default_nettype none

module alu_extend (
  alu_operand_if.exec         ops,
  output rvv_alu_pkg::vreg_t  extend_data
);

  localparam int VLEN = rvv_alu_pkg::VLEN;

  logic sext;

  assign sext = (ops.op == rvv_alu_pkg::OP_SEXT2) || (ops.op == rvv_alu_pkg::OP_SEXT4);

  // k=0 8->16, k=1 16->32, k=2 8->32
  for (genvar k = 0; k < 3; k++) begin : g_cfg
    localparam int SW = (k == 1) ? 16 : 8;
    localparam int DW = (k == 0) ? 16 : 32;
    rvv_alu_pkg::vreg_t wide;

    always_comb begin
      logic [SW-1:0] narrow;
      for (int i = 0; i < VLEN / DW; i++) begin
        narrow = ops.src2[i*SW +: SW];
        wide[i*DW +: DW] = {{(DW-SW){sext & narrow[SW-1]}}, narrow};
      end
    end
  end

  always_comb begin
    case (ops.op)
      rvv_alu_pkg::OP_ZEXT2,
      rvv_alu_pkg::OP_SEXT2: begin
        if (ops.eew == rvv_isa_pkg::EEW16)
          extend_data = g_cfg[1].wide;
        else
          extend_data = g_cfg[0].wide;
      end
      rvv_alu_pkg::OP_ZEXT4,
      rvv_alu_pkg::OP_SEXT4: extend_data = g_cfg[2].wide;
      default:               extend_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/alu_merge_move.sv
`timescale 1ns/1ps
`default_nettype none

module alu_merge_move (
  alu_operand_if.exec         ops,
  output rvv_alu_pkg::vreg_t  merge_data
);

  localparam int VLEN = rvv_alu_pkg::VLEN;

  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int EW = 8 << w;
    rvv_alu_pkg::vreg_t res;

    always_comb begin
      for (int i = 0; i < VLEN / EW; i++) begin
        res[i*EW +: EW] = ops.mask[i] ? ops.src1[i*EW +: EW] : ops.src2[i*EW +: EW];
      end
    end
  end

  always_comb begin
    merge_data = '0;
    if (ops.op == rvv_alu_pkg::OP_MOVE) begin
      merge_data = ops.src1;
    end else if (ops.op == rvv_alu_pkg::OP_MERGE) begin
      case (ops.eew)
        rvv_isa_pkg::EEW8:  merge_data = g_width[0].res;
        rvv_isa_pkg::EEW16: merge_data = g_width[1].res;
        rvv_isa_pkg::EEW32: merge_data = g_width[2].res;
        default:            merge_data = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/alu_minmax.sv
`timescale 1ns/1ps
`default_nettype none

module alu_minmax (
  alu_operand_if.exec         ops,
  output rvv_alu_pkg::vreg_t  minmax_data
);

  localparam int VLEN = rvv_alu_pkg::VLEN;

  logic is_signed;
  logic is_min;

  assign is_signed = (ops.op == rvv_alu_pkg::OP_MIN) || (ops.op == rvv_alu_pkg::OP_MAX);
  assign is_min    = (ops.op == rvv_alu_pkg::OP_MIN) || (ops.op == rvv_alu_pkg::OP_MINU);

  // one comparator array per element width
  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int EW = 8 << w;
    rvv_alu_pkg::vreg_t res;

    always_comb begin
      logic signed [EW:0] a;
      logic signed [EW:0] b;
      logic               b_lt_a;
      logic               b_gt_a;
      for (int i = 0; i < VLEN / EW; i++) begin
        // extra top bit makes one signed compare serve both kinds
        a = {is_signed & ops.src1[i*EW+EW-1], ops.src1[i*EW +: EW]};
        b = {is_signed & ops.src2[i*EW+EW-1], ops.src2[i*EW +: EW]};
        b_lt_a = b < a;
        b_gt_a = a < b;
        if (is_min)
          res[i*EW +: EW] = b_lt_a ? b[EW-1:0] : a[EW-1:0];
        else
          res[i*EW +: EW] = b_gt_a ? b[EW-1:0] : a[EW-1:0];
      end
    end
  end

  always_comb begin
    case (ops.eew)
      rvv_isa_pkg::EEW8:  minmax_data = g_width[0].res;
      rvv_isa_pkg::EEW16: minmax_data = g_width[1].res;
      rvv_isa_pkg::EEW32: minmax_data = g_width[2].res;
      default:            minmax_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/alu_operand_if.sv
`timescale 1ns/1ps
`default_nettype none

interface alu_operand_if;

  rvv_alu_pkg::alu_op_e    op;
  rvv_isa_pkg::eew_e       eew;
  rvv_alu_pkg::vreg_t      src1;
  rvv_alu_pkg::vreg_t      src2;
  rvv_alu_pkg::vmask_t     mask;
  logic                    ignore_vma;
  rvv_alu_pkg::rob_entry_t rob_entry;
  // legal uop taken this cycle
  logic                    fire;

  modport source (output op, eew, src1, src2, mask, ignore_vma, rob_entry, fire);
  modport exec   (input op, eew, src1, src2, mask);
  modport sink   (input op, eew, src1, src2, mask, ignore_vma, rob_entry, fire);

endinterface

`default_nettype wire

// File: design/alu_other_decode.sv
`timescale 1ns/1ps
`default_nettype none

module alu_other_decode (
  input  wire                         clk,
  input  wire                         reset,
  input  rvv_alu_pkg::rob_entry_t     rob_entry,
  input  rvv_isa_pkg::funct6_e        funct6,
  input  rvv_isa_pkg::funct3_e        funct3,
  input  wire                         vm,
  input  rvv_isa_pkg::vxunary_e       vs1_idx,
  input  rvv_alu_pkg::vreg_t          vs1_data,
  input  wire                         vs1_valid,
  input  rvv_alu_pkg::vreg_t          vs2_data,
  input  wire                         vs2_valid,
  input  rvv_alu_pkg::xreg_t          rs1_data,
  input  wire                         rs1_valid,
  input  rvv_alu_pkg::vreg_t          v0_data,
  input  wire                         v0_valid,
  input  rvv_isa_pkg::eew_e           vs2_eew,
  input  rvv_isa_pkg::eew_e           vd_eew,
  input  rvv_alu_pkg::uop_index_t     uop_index,
  input  wire                         uop_xfer,
  alu_operand_if.source               ops
);

  localparam int VLEN = rvv_alu_pkg::VLEN;

  rvv_alu_pkg::alu_op_e op;
  logic                 src1_ok;
  logic                 vf2_eew_ok;
  logic                 vf4_eew_ok;
  rvv_isa_pkg::eew_e    splat_eew;

  function automatic rvv_alu_pkg::vreg_t splat(input rvv_isa_pkg::eew_e ew,
                                               input rvv_alu_pkg::xreg_t x);
    rvv_alu_pkg::vreg_t v;
    v = '0;
    case (ew)
      rvv_isa_pkg::EEW8:  v = {(VLEN/8){x[7:0]}};
      rvv_isa_pkg::EEW16: v = {(VLEN/16){x[15:0]}};
      rvv_isa_pkg::EEW32: v = {(VLEN/rvv_alu_pkg::XLEN){x}};
      default:            v = '0;
    endcase
    return v;
  endfunction

  // vector-vector takes vs1, the scalar forms take rs1 or the immediate
  assign src1_ok    = (funct3 == rvv_isa_pkg::OPIVV) ? vs1_valid : rs1_valid;
  assign vf2_eew_ok = (vs2_eew == rvv_isa_pkg::EEW8) || (vs2_eew == rvv_isa_pkg::EEW16);
  assign vf4_eew_ok = (vs2_eew == rvv_isa_pkg::EEW8);

  always_comb begin
    op = rvv_alu_pkg::OP_NONE;
    case (funct3)
      rvv_isa_pkg::OPIVV,
      rvv_isa_pkg::OPIVX,
      rvv_isa_pkg::OPIVI: begin
        // min/max has no immediate form
        if (funct6 == rvv_isa_pkg::VMERGE_VMV) begin
          if (vm && src1_ok)
            op = rvv_alu_pkg::OP_MOVE;
          else if (!vm && src1_ok && vs2_valid && v0_valid)
            op = rvv_alu_pkg::OP_MERGE;
        end else if (funct3 != rvv_isa_pkg::OPIVI && src1_ok && vs2_valid) begin
          case (funct6)
            rvv_isa_pkg::VMINU: op = rvv_alu_pkg::OP_MINU;
            rvv_isa_pkg::VMIN:  op = rvv_alu_pkg::OP_MIN;
            rvv_isa_pkg::VMAXU: op = rvv_alu_pkg::OP_MAXU;
            rvv_isa_pkg::VMAX:  op = rvv_alu_pkg::OP_MAX;
            default:            op = rvv_alu_pkg::OP_NONE;
          endcase
        end
      end
      rvv_isa_pkg::OPMVV: begin
        if (funct6 == rvv_isa_pkg::VXUNARY0 && !vs1_valid && vs2_valid) begin
          case (vs1_idx)
            rvv_isa_pkg::VZEXT_VF2: op = vf2_eew_ok ? rvv_alu_pkg::OP_ZEXT2 : rvv_alu_pkg::OP_NONE;
            rvv_isa_pkg::VSEXT_VF2: op = vf2_eew_ok ? rvv_alu_pkg::OP_SEXT2 : rvv_alu_pkg::OP_NONE;
            rvv_isa_pkg::VZEXT_VF4: op = vf4_eew_ok ? rvv_alu_pkg::OP_ZEXT4 : rvv_alu_pkg::OP_NONE;
            rvv_isa_pkg::VSEXT_VF4: op = vf4_eew_ok ? rvv_alu_pkg::OP_SEXT4 : rvv_alu_pkg::OP_NONE;
            default:                op = rvv_alu_pkg::OP_NONE;
          endcase
        end
      end
      default: op = rvv_alu_pkg::OP_NONE;
    endcase
  end

  // vmv.v.x/i splats at the destination width
  assign splat_eew = (op == rvv_alu_pkg::OP_MOVE) ? vd_eew : vs2_eew;

  always_comb begin
    if (funct3 == rvv_isa_pkg::OPIVV)
      ops.src1 = vs1_data;
    else
      ops.src1 = splat(splat_eew, rs1_data);
  end

  // extend reads one half or quarter of vs2, copied across the register
  always_comb begin
    case (op)
      rvv_alu_pkg::OP_ZEXT2,
      rvv_alu_pkg::OP_SEXT2: ops.src2 = {2{vs2_data[uop_index[0]*(VLEN/2) +: VLEN/2]}};
      rvv_alu_pkg::OP_ZEXT4,
      rvv_alu_pkg::OP_SEXT4: ops.src2 = {4{vs2_data[uop_index[1:0]*(VLEN/4) +: VLEN/4]}};
      default:               ops.src2 = vs2_data;
    endcase
  end

  // v0 bits for the elements of this uop
  always_comb begin
    case (vs2_eew)
      rvv_isa_pkg::EEW16: ops.mask = v0_data[{uop_index, 3'b0} +: rvv_alu_pkg::VLENB];
      rvv_isa_pkg::EEW32: ops.mask = v0_data[{uop_index, 2'b0} +: rvv_alu_pkg::VLENB];
      default:            ops.mask = v0_data[{uop_index, 4'b0} +: rvv_alu_pkg::VLENB];
    endcase
  end

  assign ops.op         = op;
  assign ops.eew        = vs2_eew;
  assign ops.ignore_vma = (op == rvv_alu_pkg::OP_MERGE);
  assign ops.rob_entry  = rob_entry;
  assign ops.fire       = uop_xfer && (op != rvv_alu_pkg::OP_NONE);

  // issue never sends a vs1 operand with an extend
  assert property (@(posedge clk) disable iff (reset)
    (uop_xfer && funct3 == rvv_isa_pkg::OPMVV && funct6 == rvv_isa_pkg::VXUNARY0)
      |-> !vs1_valid);

endmodule

`default_nettype wire

// File: design/alu_result_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result_buffer (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       uop_valid,
  alu_operand_if.sink               ops,
  input  rvv_alu_pkg::vreg_t        minmax_data,
  input  rvv_alu_pkg::vreg_t        extend_data,
  input  rvv_alu_pkg::vreg_t        merge_data,
  input  wire                       result_ready,
  output logic                      uop_ready,
  output logic                      uop_xfer,
  output logic                      result_valid,
  output rvv_alu_pkg::rob_entry_t   result_rob_entry,
  output rvv_alu_pkg::vreg_t        result_data,
  output logic                      result_ignore_vma
);

  rvv_alu_pkg::vreg_t sel_data;

  // room when empty or when the held result leaves this cycle
  assign uop_ready = !result_valid || result_ready;
  assign uop_xfer  = uop_valid && uop_ready;

  always_comb begin
    case (ops.op)
      rvv_alu_pkg::OP_MINU,
      rvv_alu_pkg::OP_MIN,
      rvv_alu_pkg::OP_MAXU,
      rvv_alu_pkg::OP_MAX:   sel_data = minmax_data;
      rvv_alu_pkg::OP_MERGE,
      rvv_alu_pkg::OP_MOVE:  sel_data = merge_data;
      rvv_alu_pkg::OP_ZEXT2,
      rvv_alu_pkg::OP_SEXT2,
      rvv_alu_pkg::OP_ZEXT4,
      rvv_alu_pkg::OP_SEXT4: sel_data = extend_data;
      default:               sel_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset)
      result_valid <= 1'b0;
    else if (ops.fire)
      result_valid <= 1'b1;
    else if (result_ready)
      result_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (ops.fire) begin
      result_data       <= sel_data;
      result_rob_entry  <= ops.rob_entry;
      result_ignore_vma <= ops.ignore_vma;
    end
  end

  // stalled result must not change
  assert property (@(posedge clk) disable iff (reset)
    (result_valid && !result_ready) |=> (result_valid && $stable(result_data) &&
      $stable(result_rob_entry) && $stable(result_ignore_vma)));

  assert property (@(posedge clk) reset |=> !result_valid);

endmodule

`default_nettype wire

// File: design/rvv_alu_other.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_other (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       uop_valid,
  output logic                      uop_ready,
  input  rvv_alu_pkg::rob_entry_t   rob_entry,
  input  rvv_isa_pkg::funct6_e      funct6,
  input  rvv_isa_pkg::funct3_e      funct3,
  input  wire                       vm,
  input  rvv_isa_pkg::vxunary_e     vs1_idx,
  input  rvv_alu_pkg::vreg_t        vs1_data,
  input  wire                       vs1_valid,
  input  rvv_alu_pkg::vreg_t        vs2_data,
  input  wire                       vs2_valid,
  input  rvv_alu_pkg::xreg_t        rs1_data,
  input  wire                       rs1_valid,
  input  rvv_alu_pkg::vreg_t        v0_data,
  input  wire                       v0_valid,
  input  rvv_isa_pkg::eew_e         vs2_eew,
  input  rvv_isa_pkg::eew_e         vd_eew,
  input  rvv_alu_pkg::uop_index_t   uop_index,
  output logic                      result_valid,
  input  wire                       result_ready,
  output rvv_alu_pkg::rob_entry_t   result_rob_entry,
  output rvv_alu_pkg::vreg_t        result_data,
  output logic                      result_ignore_vma
);

  alu_operand_if ops ();

  logic               uop_xfer;
  rvv_alu_pkg::vreg_t minmax_data;
  rvv_alu_pkg::vreg_t extend_data;
  rvv_alu_pkg::vreg_t merge_data;

  alu_other_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .rob_entry (rob_entry),
    .funct6    (funct6),
    .funct3    (funct3),
    .vm        (vm),
    .vs1_idx   (vs1_idx),
    .vs1_data  (vs1_data),
    .vs1_valid (vs1_valid),
    .vs2_data  (vs2_data),
    .vs2_valid (vs2_valid),
    .rs1_data  (rs1_data),
    .rs1_valid (rs1_valid),
    .v0_data   (v0_data),
    .v0_valid  (v0_valid),
    .vs2_eew   (vs2_eew),
    .vd_eew    (vd_eew),
    .uop_index (uop_index),
    .uop_xfer  (uop_xfer),
    .ops       (ops.source)
  );

  alu_minmax u_minmax (
    .ops         (ops.exec),
    .minmax_data (minmax_data)
  );

  alu_extend u_extend (
    .ops         (ops.exec),
    .extend_data (extend_data)
  );

  alu_merge_move u_merge_move (
    .ops        (ops.exec),
    .merge_data (merge_data)
  );

  alu_result_buffer u_result_buffer (
    .clk               (clk),
    .reset             (reset),
    .uop_valid         (uop_valid),
    .ops               (ops.sink),
    .minmax_data       (minmax_data),
    .extend_data       (extend_data),
    .merge_data        (merge_data),
    .result_ready      (result_ready),
    .uop_ready         (uop_ready),
    .uop_xfer          (uop_xfer),
    .result_valid      (result_valid),
    .result_rob_entry  (result_rob_entry),
    .result_data       (result_data),
    .result_ignore_vma (result_ignore_vma)
  );

endmodule

`default_nettype wire

// File: design/rvv_alu_pkg.sv
`default_nettype none

package rvv_alu_pkg;

  localparam int VLEN            = 128;
  localparam int XLEN            = 32;
  localparam int VLENB           = VLEN / 8;
  localparam int ROB_DEPTH_WIDTH = 4;
  localparam int UOP_INDEX_WIDTH = 3;

  typedef logic [VLEN-1:0]            vreg_t;
  typedef logic [XLEN-1:0]            xreg_t;
  // one bit per byte lane, enough for EEW8
  typedef logic [VLENB-1:0]           vmask_t;
  typedef logic [ROB_DEPTH_WIDTH-1:0] rob_entry_t;
  typedef logic [UOP_INDEX_WIDTH-1:0] uop_index_t;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_MINU,
    OP_MIN,
    OP_MAXU,
    OP_MAX,
    OP_MERGE,
    OP_MOVE,
    OP_ZEXT2,
    OP_SEXT2,
    OP_ZEXT4,
    OP_SEXT4
  } alu_op_e;

endpackage

`default_nettype wire

// File: design/rvv_isa_pkg.sv
`default_nettype none

package rvv_isa_pkg;

  // major opcode category of OP-V
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110
  } funct3_e;

  // arithmetic funct6 codes handled by this lane
  typedef enum logic [5:0] {
    VMINU      = 6'b000100,
    VMIN       = 6'b000101,
    VMAXU      = 6'b000110,
    VMAX       = 6'b000111,
    VXUNARY0   = 6'b010010,
    VMERGE_VMV = 6'b010111
  } funct6_e;

  // vs1 field selects the unary op under VXUNARY0
  typedef enum logic [4:0] {
    VZEXT_VF4 = 5'b00100,
    VSEXT_VF4 = 5'b00101,
    VZEXT_VF2 = 5'b00110,
    VSEXT_VF2 = 5'b00111
  } vxunary_e;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

endpackage

`default_nettype wire

// File: files.f
+incdir+include
design/rvv_isa_pkg.sv
design/rvv_alu_pkg.sv
design/alu_operand_if.sv
design/alu_other_decode.sv
design/alu_minmax.sv
design/alu_extend.sv
design/alu_merge_move.sv
design/alu_result_buffer.sv
design/rvv_alu_other.sv
test/tb_rvv_alu_other.sv

// File: include/tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

logic [31:0] lcg_state = 32'h92f1;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// halves swapped so the low bits are usable
function automatic logic [31:0] rand32();
  lcg_state = lcg_next(lcg_state);
  return {lcg_state[15:0], lcg_state[31:16]};
endfunction

function automatic rvv_alu_pkg::vreg_t rand_vreg();
  return {rand32(), rand32(), rand32(), rand32()};
endfunction

function automatic logic [31:0] get_elem(input rvv_alu_pkg::vreg_t v, input int w,
                                         input int i);
  logic [127:0] m;
  m = (128'd1 << w) - 128'd1;
  return 32'((v >> (i * w)) & m);
endfunction

function automatic rvv_alu_pkg::vreg_t put_elem(input rvv_alu_pkg::vreg_t v, input int w,
                                                input int i, input logic [31:0] e);
  logic [127:0] m;
  m = (128'd1 << w) - 128'd1;
  return v | (({96'd0, e} & m) << (i * w));
endfunction

// numeric value of a w-bit element
function automatic longint elem_value(input logic [31:0] e, input int w, input logic sgn);
  longint val;
  val = longint'({32'd0, e});
  if (sgn && e[w-1])
    val = val - (longint'(1) << w);
  return val;
endfunction

function automatic rvv_alu_pkg::vreg_t splat_scalar(input rvv_alu_pkg::xreg_t x, input int w);
  rvv_alu_pkg::vreg_t v;
  v = '0;
  for (int i = 0; i < rvv_alu_pkg::VLEN / w; i++)
    v = put_elem(v, w, i, x);
  return v;
endfunction

function automatic rvv_alu_pkg::vreg_t model_alu(
  input rvv_isa_pkg::funct6_e f6, input rvv_isa_pkg::funct3_e f3, input logic vm,
  input rvv_isa_pkg::vxunary_e idx, input logic v1ok, input rvv_alu_pkg::vreg_t vs1,
  input logic v2ok, input rvv_alu_pkg::vreg_t vs2, input logic xok,
  input rvv_alu_pkg::xreg_t rs1, input logic v0ok, input rvv_alu_pkg::vreg_t v0,
  input rvv_isa_pkg::eew_e ew, input rvv_isa_pkg::eew_e dew,
  input rvv_alu_pkg::uop_index_t ui, output logic has_res, output logic ivma);
  rvv_alu_pkg::vreg_t res;
  rvv_alu_pkg::vreg_t opa;
  logic               src_ok;
  logic               sgn;
  logic               pick_b;
  logic [31:0]        e;
  int                 sw;
  int                 dw;
  int                 fac;
  int                 n;
  longint             a;
  longint             b;
  res     = '0;
  has_res = 1'b0;
  ivma    = 1'b0;
  sw      = 8 << ew;
  n       = rvv_alu_pkg::VLEN / sw;
  src_ok  = (f3 == rvv_isa_pkg::OPIVV) ? v1ok : xok;
  if (f3 == rvv_isa_pkg::OPIVV)
    opa = vs1;
  else if (f6 == rvv_isa_pkg::VMERGE_VMV && vm)
    opa = splat_scalar(rs1, 8 << dew);
  else
    opa = splat_scalar(rs1, sw);
  case (f6)
    rvv_isa_pkg::VMINU, rvv_isa_pkg::VMIN, rvv_isa_pkg::VMAXU, rvv_isa_pkg::VMAX: begin
      if (f3 == rvv_isa_pkg::OPIVV || f3 == rvv_isa_pkg::OPIVX) begin
        has_res = src_ok && v2ok;
        sgn = (f6 == rvv_isa_pkg::VMIN) || (f6 == rvv_isa_pkg::VMAX);
        for (int i = 0; i < n; i++) begin
          a = elem_value(get_elem(opa, sw, i), sw, sgn);
          b = elem_value(get_elem(vs2, sw, i), sw, sgn);
          // ties keep the first operand
          if (f6 == rvv_isa_pkg::VMINU || f6 == rvv_isa_pkg::VMIN)
            pick_b = b < a;
          else
            pick_b = b > a;
          e = pick_b ? get_elem(vs2, sw, i) : get_elem(opa, sw, i);
          res = put_elem(res, sw, i, e);
        end
      end
    end
    rvv_isa_pkg::VMERGE_VMV: begin
      if (f3 == rvv_isa_pkg::OPIVV || f3 == rvv_isa_pkg::OPIVX || f3 == rvv_isa_pkg::OPIVI) begin
        if (vm) begin
          has_res = src_ok;
          res = opa;
        end else begin
          has_res = src_ok && v2ok && v0ok;
          ivma = has_res;
          for (int i = 0; i < n; i++) begin
            e = v0[int'(ui) * n + i] ? get_elem(opa, sw, i) : get_elem(vs2, sw, i);
            res = put_elem(res, sw, i, e);
          end
        end
      end
    end
    rvv_isa_pkg::VXUNARY0: begin
      fac = 0;
      if (idx == rvv_isa_pkg::VZEXT_VF2 || idx == rvv_isa_pkg::VSEXT_VF2)
        fac = 2;
      if (idx == rvv_isa_pkg::VZEXT_VF4 || idx == rvv_isa_pkg::VSEXT_VF4)
        fac = 4;
      sgn = (idx == rvv_isa_pkg::VSEXT_VF2) || (idx == rvv_isa_pkg::VSEXT_VF4);
      if (f3 == rvv_isa_pkg::OPMVV && !v1ok && v2ok &&
          ((fac == 2 && sw <= 16) || (fac == 4 && sw == 8))) begin
        has_res = 1'b1;
        dw = sw * fac;
        n = rvv_alu_pkg::VLEN / dw;
        // uop k reads part k mod fac of the source register
        for (int i = 0; i < n; i++) begin
          a = elem_value(get_elem(vs2, sw, (int'(ui) % fac) * n + i), sw, sgn);
          res = put_elem(res, dw, i, 32'(a));
        end
      end
    end
    default: has_res = 1'b0;
  endcase
  return res;
endfunction

`endif

// File: test/tb_rvv_alu_other.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_alu_other;

  localparam int NUM_UOPS        = 205;
  localparam int WATCHDOG_CYCLES = 2 * NUM_UOPS * 8;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    uop_valid;
  logic                    uop_ready;
  rvv_alu_pkg::rob_entry_t rob_entry;
  rvv_isa_pkg::funct6_e    funct6;
  rvv_isa_pkg::funct3_e    funct3;
  logic                    vm;
  rvv_isa_pkg::vxunary_e   vs1_idx;
  rvv_alu_pkg::vreg_t      vs1_data;
  logic                    vs1_valid;
  rvv_alu_pkg::vreg_t      vs2_data;
  logic                    vs2_valid;
  rvv_alu_pkg::xreg_t      rs1_data;
  logic                    rs1_valid;
  rvv_alu_pkg::vreg_t      v0_data;
  logic                    v0_valid;
  rvv_isa_pkg::eew_e       vs2_eew;
  rvv_isa_pkg::eew_e       vd_eew;
  rvv_alu_pkg::uop_index_t uop_index;
  logic                    result_valid;
  logic                    result_ready = 1'b0;
  rvv_alu_pkg::rob_entry_t result_rob_entry;
  rvv_alu_pkg::vreg_t      result_data;
  logic                    result_ignore_vma;

  rvv_alu_pkg::vreg_t      exp_q[$];
  rvv_alu_pkg::rob_entry_t rob_q[$];
  logic                    ivma_q[$];
  string                   name_q[$];

  int                      errors = 0;
  int                      checks = 0;
  rvv_alu_pkg::rob_entry_t next_rob = '0;
  logic [31:0]             rdy_state = 32'h92f1;
  logic                    held = 1'b0;
  rvv_alu_pkg::vreg_t      held_data;
  rvv_alu_pkg::rob_entry_t held_rob;
  logic                    held_ivma;
  string                   cmp_name;
  logic                    cur_has = 1'b0;
  logic                    buf_full = 1'b0;
  logic                    exp_ready;

  rvv_isa_pkg::funct6_e  mm_ops[4] = '{rvv_isa_pkg::VMINU, rvv_isa_pkg::VMIN,
                                       rvv_isa_pkg::VMAXU, rvv_isa_pkg::VMAX};
  rvv_isa_pkg::funct3_e  mv_forms[3] = '{rvv_isa_pkg::OPIVV, rvv_isa_pkg::OPIVX,
                                         rvv_isa_pkg::OPIVI};
  rvv_isa_pkg::vxunary_e ext_idx[6] = '{rvv_isa_pkg::VZEXT_VF2, rvv_isa_pkg::VSEXT_VF2,
                                        rvv_isa_pkg::VZEXT_VF2, rvv_isa_pkg::VSEXT_VF2,
                                        rvv_isa_pkg::VZEXT_VF4, rvv_isa_pkg::VSEXT_VF4};
  rvv_isa_pkg::eew_e     ext_eew[6] = '{rvv_isa_pkg::EEW8, rvv_isa_pkg::EEW8,
                                        rvv_isa_pkg::EEW16, rvv_isa_pkg::EEW16,
                                        rvv_isa_pkg::EEW8, rvv_isa_pkg::EEW8};

  `include "tb_alu_model.svh"

  rvv_alu_other u_rvv_alu_other (
    .clk               (clk),
    .reset             (reset),
    .uop_valid         (uop_valid),
    .uop_ready         (uop_ready),
    .rob_entry         (rob_entry),
    .funct6            (funct6),
    .funct3            (funct3),
    .vm                (vm),
    .vs1_idx           (vs1_idx),
    .vs1_data          (vs1_data),
    .vs1_valid         (vs1_valid),
    .vs2_data          (vs2_data),
    .vs2_valid         (vs2_valid),
    .rs1_data          (rs1_data),
    .rs1_valid         (rs1_valid),
    .v0_data           (v0_data),
    .v0_valid          (v0_valid),
    .vs2_eew           (vs2_eew),
    .vd_eew            (vd_eew),
    .uop_index         (uop_index),
    .result_valid      (result_valid),
    .result_ready      (result_ready),
    .result_rob_entry  (result_rob_entry),
    .result_data       (result_data),
    .result_ignore_vma (result_ignore_vma)
  );

  always #4 clk = ~clk;

  // ready is low about a quarter of the time
  always @(posedge clk) begin
    rdy_state = lcg_next(rdy_state);
    result_ready <= rdy_state[28] | rdy_state[21];
  end

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  function automatic rvv_isa_pkg::eew_e eew_of(input int w);
    return rvv_isa_pkg::eew_e'(2'(w));
  endfunction

  // oks is {vs1, vs2, rs1, v0} valid
  task automatic send_uop(input string name, input rvv_isa_pkg::funct6_e f6,
                          input rvv_isa_pkg::funct3_e f3, input logic vm_bit,
                          input rvv_isa_pkg::vxunary_e idx, input logic [3:0] oks,
                          input rvv_isa_pkg::eew_e ew, input rvv_isa_pkg::eew_e dew,
                          input rvv_alu_pkg::uop_index_t ui);
    rvv_alu_pkg::vreg_t a;
    rvv_alu_pkg::vreg_t b;
    rvv_alu_pkg::vreg_t m;
    rvv_alu_pkg::xreg_t x;
    rvv_alu_pkg::vreg_t expected;
    logic               has;
    logic               ivma;
    a = rand_vreg();
    b = rand_vreg();
    m = rand_vreg();
    x = rand32();
    // immediate forms carry a sign-extended simm5
    if (f3 == rvv_isa_pkg::OPIVI)
      x = {{27{x[4]}}, x[4:0]};
    expected = model_alu(f6, f3, vm_bit, idx, oks[3], a, oks[2], b, oks[1], x, oks[0], m,
                         ew, dew, ui, has, ivma);
    @(posedge clk);
    cur_has = has;
    uop_valid <= 1'b1;
    rob_entry <= next_rob;
    funct6    <= f6;
    funct3    <= f3;
    vm        <= vm_bit;
    vs1_idx   <= idx;
    vs1_data  <= a;
    vs1_valid <= oks[3];
    vs2_data  <= b;
    vs2_valid <= oks[2];
    rs1_data  <= x;
    rs1_valid <= oks[1];
    v0_data   <= m;
    v0_valid  <= oks[0];
    vs2_eew   <= ew;
    vd_eew    <= dew;
    uop_index <= ui;
    @(negedge clk);
    while (!uop_ready)
      @(negedge clk);
    // transfer happens at the coming edge
    if (has) begin
      exp_q.push_back(expected);
      rob_q.push_back(next_rob);
      ivma_q.push_back(ivma);
      name_q.push_back(name);
    end
    next_rob = next_rob + 4'd1;
  endtask

  task automatic run_minmax();
    rvv_isa_pkg::funct6_e f6;
    rvv_isa_pkg::funct3_e f3;
    for (int k = 0; k < 4; k++) begin
      f6 = mm_ops[k];
      for (int f = 0; f < 2; f++) begin
        f3 = (f == 0) ? rvv_isa_pkg::OPIVV : rvv_isa_pkg::OPIVX;
        for (int w = 0; w < 3; w++) begin
          for (int r = 0; r < 4; r++) begin
            send_uop($sformatf("%s %s e%0d", f6.name(), f3.name(), 8 << w), f6, f3, 1'b1,
                     rvv_isa_pkg::VZEXT_VF2, 4'b1110, eew_of(w), rvv_isa_pkg::EEW8, 3'd0);
          end
        end
      end
    end
  endtask

  task automatic run_merge_move();
    rvv_isa_pkg::funct3_e f3;
    logic                 vm_bit;
    for (int f = 0; f < 3; f++) begin
      f3 = mv_forms[f];
      for (int w = 0; w < 3; w++) begin
        for (int r = 0; r < 5; r++) begin
          vm_bit = (r >= 3);
          send_uop($sformatf("%s %s e%0d", vm_bit ? "vmv.v" : "vmerge", f3.name(), 8 << w),
                   rvv_isa_pkg::VMERGE_VMV, f3, vm_bit, rvv_isa_pkg::VZEXT_VF2, 4'b1111,
                   eew_of(w), eew_of(int'(rand32() % 32'd3)),
                   rvv_alu_pkg::uop_index_t'(rand32()));
        end
      end
    end
  endtask

  task automatic run_extend();
    rvv_isa_pkg::vxunary_e idx;
    for (int k = 0; k < 6; k++) begin
      idx = ext_idx[k];
      for (int u = 0; u < 8; u++) begin
        send_uop($sformatf("%s e%0d uop%0d", idx.name(), 8 << ext_eew[k], u),
                 rvv_isa_pkg::VXUNARY0, rvv_isa_pkg::OPMVV, 1'b1, idx, 4'b0100,
                 ext_eew[k], rvv_isa_pkg::EEW8, rvv_alu_pkg::uop_index_t'(u));
      end
    end
  endtask

  // a legal uop right behind each illegal one shows the order is kept
  task automatic bad_then_good(input string name, input rvv_isa_pkg::funct6_e f6,
                               input rvv_isa_pkg::funct3_e f3, input logic vm_bit,
                               input rvv_isa_pkg::vxunary_e idx, input logic [3:0] oks,
                               input rvv_isa_pkg::eew_e ew);
    send_uop({"illegal ", name}, f6, f3, vm_bit, idx, oks, ew, rvv_isa_pkg::EEW8, 3'd0);
    send_uop({"after ", name}, rvv_isa_pkg::VMAXU, rvv_isa_pkg::OPIVV, 1'b1,
             rvv_isa_pkg::VZEXT_VF2, 4'b1110, ew, rvv_isa_pkg::EEW8, 3'd0);
  endtask

  task automatic run_illegal();
    bad_then_good("vmin no vs2", rvv_isa_pkg::VMIN, rvv_isa_pkg::OPIVV, 1'b1,
                  rvv_isa_pkg::VZEXT_VF2, 4'b1011, rvv_isa_pkg::EEW8);
    bad_then_good("vminu no vs1", rvv_isa_pkg::VMINU, rvv_isa_pkg::OPIVV, 1'b1,
                  rvv_isa_pkg::VZEXT_VF2, 4'b0111, rvv_isa_pkg::EEW16);
    bad_then_good("vmax.vx no rs1", rvv_isa_pkg::VMAX, rvv_isa_pkg::OPIVX, 1'b1,
                  rvv_isa_pkg::VZEXT_VF2, 4'b1101, rvv_isa_pkg::EEW32);
    bad_then_good("vmax.vi", rvv_isa_pkg::VMAX, rvv_isa_pkg::OPIVI, 1'b1,
                  rvv_isa_pkg::VZEXT_VF2, 4'b1111, rvv_isa_pkg::EEW8);
    bad_then_good("vmerge no v0", rvv_isa_pkg::VMERGE_VMV, rvv_isa_pkg::OPIVV, 1'b0,
                  rvv_isa_pkg::VZEXT_VF2, 4'b1110, rvv_isa_pkg::EEW16);
    bad_then_good("vsext.vf4 e16", rvv_isa_pkg::VXUNARY0, rvv_isa_pkg::OPMVV, 1'b1,
                  rvv_isa_pkg::VSEXT_VF4, 4'b0111, rvv_isa_pkg::EEW16);
    bad_then_good("vzext.vf2 e32", rvv_isa_pkg::VXUNARY0, rvv_isa_pkg::OPMVV, 1'b1,
                  rvv_isa_pkg::VZEXT_VF2, 4'b0111, rvv_isa_pkg::EEW32);
    bad_then_good("funct6 000000", rvv_isa_pkg::funct6_e'(6'b000000), rvv_isa_pkg::OPIVV,
                  1'b1, rvv_isa_pkg::VZEXT_VF2, 4'b1111, rvv_isa_pkg::EEW8);
  endtask

  // sampled at the falling edge, away from the driving edge
  always @(negedge clk) begin
    if (!reset) begin
      // expected occupancy of the result register, empty right after reset
      exp_ready = !buf_full || result_ready;
      check_value("result valid", 128'(buf_full), 128'(result_valid));
      check_value("uop ready", 128'(exp_ready), 128'(uop_ready));
      if (held) begin
        check_value("stall valid", 128'(1'b1), 128'(result_valid));
        check_value("stall data", held_data, result_data);
        check_value("stall rob", 128'(held_rob), 128'(result_rob_entry));
        check_value("stall vma", 128'(held_ivma), 128'(result_ignore_vma));
      end
      if (result_valid && result_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("a result arrived while no uop was expecting one");
        end else begin
          cmp_name = name_q.pop_front();
          check_value(cmp_name, exp_q.pop_front(), result_data);
          check_value({cmp_name, " rob"}, 128'(rob_q.pop_front()), 128'(result_rob_entry));
          check_value({cmp_name, " vma"}, 128'(ivma_q.pop_front()), 128'(result_ignore_vma));
        end
      end
      buf_full  = (uop_valid && exp_ready && cur_has) || (buf_full && !result_ready);
      held      = result_valid && !result_ready;
      held_data = result_data;
      held_rob  = result_rob_entry;
      held_ivma = result_ignore_vma;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 8);
    $display("timeout after %0d cycles with %0d results still outstanding",
             WATCHDOG_CYCLES, exp_q.size());
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    reset        = 1'b1;
    uop_valid    = 1'b0;
    rob_entry    = '0;
    funct6       = rvv_isa_pkg::VMINU;
    funct3       = rvv_isa_pkg::OPIVV;
    vm           = 1'b1;
    vs1_idx      = rvv_isa_pkg::VZEXT_VF2;
    vs1_data     = '0;
    vs1_valid    = 1'b0;
    vs2_data     = '0;
    vs2_valid    = 1'b0;
    rs1_data     = '0;
    rs1_valid    = 1'b0;
    v0_data      = '0;
    v0_valid     = 1'b0;
    vs2_eew      = rvv_isa_pkg::EEW8;
    vd_eew       = rvv_isa_pkg::EEW8;
    uop_index    = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    run_minmax();
    run_merge_move();
    run_extend();
    run_illegal();
    @(posedge clk);
    uop_valid <= 1'b0;
    while (exp_q.size() != 0 || result_valid)
      @(negedge clk);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
